/* stb_pkg.sv */
package stb_pkg;

    // Queue sizing
    localparam int STB_DEPTH = 8;
    localparam int STB_IDX_W = $clog2(STB_DEPTH);  // Entry index bits
    localparam int STB_PTR_W = STB_IDX_W + 1;       // Index plus wrap bit

    // Drain controller states
    typedef enum logic [1:0] {
        IDLE           = 2'b00,
        SB_CACHE_WRITE = 2'b01
    } stb_state_t;

endpackage

/* mem_access_pkg.sv */
package mem_access_pkg;

    localparam int ADDR_W     = 32;              // Byte address
    localparam int DATA_W     = 32;              // One data word
    localparam int MASK_W     = DATA_W / 8;      // One bit per byte lane
    localparam int BYTE_OFF_W = $clog2(MASK_W);  // Byte offset within a word

    // Store size as issued by the LSU
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } store_size_t;

endpackage

/* lsu_store_align.sv */
module lsu_store_align import mem_access_pkg::*; (
    input  logic [ADDR_W-1:0] addr,       // Byte address from LSU
    input  logic [DATA_W-1:0] wdata,      // Store data, right justified
    input  store_size_t       size,
    output logic [ADDR_W-1:0] word_addr,  // Address with offset cleared
    output logic [DATA_W-1:0] lane_data,
    output logic [MASK_W-1:0] byte_mask
);

    logic [BYTE_OFF_W-1:0] offset;

    assign offset = addr[BYTE_OFF_W-1:0];

    // Cache is word addressed
    assign word_addr = {addr[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};

    // Replicate the store across all lanes, the mask picks the live ones
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                lane_data = {MASK_W{wdata[7:0]}};
                byte_mask = MASK_W'(1) << offset;
            end
            SIZE_HALF: begin
                lane_data = {(MASK_W / 2){wdata[15:0]}};
                // Halfwords are aligned, so only the upper offset bit matters
                if (offset[BYTE_OFF_W-1])
                    byte_mask = {{(MASK_W / 2){1'b1}}, {(MASK_W / 2){1'b0}}};
                else
                    byte_mask = {{(MASK_W / 2){1'b0}}, {(MASK_W / 2){1'b1}}};
            end
            SIZE_WORD: begin
                lane_data = wdata;
                byte_mask = {MASK_W{1'b1}};
            end
            default: begin
                lane_data = wdata;           // Treat unknown sizes as a full word
                byte_mask = {MASK_W{1'b1}};
            end
        endcase
    end

endmodule

/* stb_datapath.sv */
module stb_datapath import stb_pkg::*, mem_access_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // Aligned store from the LSU side
    input  logic              wr_en,       // Already gated with full at the top
    input  logic [ADDR_W-1:0] in_addr,
    input  logic [DATA_W-1:0] in_data,
    input  logic [MASK_W-1:0] in_mask,

    // Controls from the cache controller
    input  logic              rd_en,       // Frees the head entry
    input  logic              rd_sel,      // 1 selects queue head, 0 selects bypass

    // Aligned store for the bypass path
    input  logic [ADDR_W-1:0] byp_addr,
    input  logic [DATA_W-1:0] byp_data,
    input  logic [MASK_W-1:0] byp_mask,

    output logic              stb_full,
    output logic              stb_empty,
    output logic [ADDR_W-1:0] out_addr,
    output logic [DATA_W-1:0] out_data,
    output logic [MASK_W-1:0] out_mask
);

    // Queue storage
    logic [ADDR_W-1:0] addr_mem [STB_DEPTH];
    logic [DATA_W-1:0] data_mem [STB_DEPTH];
    logic [MASK_W-1:0] mask_mem [STB_DEPTH];

    logic [STB_PTR_W-1:0] wr_ptr;
    logic [STB_PTR_W-1:0] rd_ptr;
    logic [STB_IDX_W-1:0] wr_idx;
    logic [STB_IDX_W-1:0] rd_idx;
    logic                 do_write;
    logic                 do_read;

    assign wr_idx = wr_ptr[STB_IDX_W-1:0];
    assign rd_idx = rd_ptr[STB_IDX_W-1:0];

    // Flags from registered pointers only
    assign stb_empty = (wr_ptr == rd_ptr);
    assign stb_full  = (wr_ptr[STB_PTR_W-1] != rd_ptr[STB_PTR_W-1]) &&
                       (wr_idx == rd_idx);

    assign do_write = wr_en && !stb_full;
    assign do_read  = rd_en && !stb_empty;  // Guard against a stray read

    // Write counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Read counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (do_write) begin
            addr_mem[wr_idx] <= in_addr;
            data_mem[wr_idx] <= in_data;
            mask_mem[wr_idx] <= in_mask;
        end
    end

    // Cache-side mux
    always_comb begin
        if (rd_sel) begin
            out_addr = addr_mem[rd_idx];
            out_data = data_mem[rd_idx];
            out_mask = mask_mem[rd_idx];
        end else begin
            out_addr = byp_addr;
            out_data = byp_data;
            out_mask = byp_mask;
        end
    end

endmodule

/* stb_cache_controller.sv */
module stb_cache_controller import stb_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    // Queue status
    input  logic stb_full,
    input  logic stb_empty,
    input  logic stb_bypass,        // LSU goes straight to the cache

    // From the data cache
    input  logic dcache2stb_ack,    // One-cycle pulse per accepted write

    // From the LSU
    input  logic lsummu2stb_w_en,
    input  logic lsummu2stb_req,
    input  logic dmem_sel_i,

    // To the datapath
    output logic stb_rd_en,         // Advances the read counter
    output logic rd_sel,            // Head entry onto the cache port

    // To the data cache
    output logic stb2dcache_req,
    output logic stb2dcache_w_en,
    output logic dmem_sel_o
);

    stb_state_t current_state;
    stb_state_t next_state;

    // Drain-side request, before the bypass mux
    logic drain_req;
    logic drain_w_en;
    logic drain_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_state <= IDLE;
        end else begin
            current_state <= next_state;
        end
    end

    // Mealy outputs, request rises in the cycle the queue holds data
    always_comb begin
        next_state = current_state;
        drain_req  = 1'b0;
        drain_w_en = 1'b0;
        drain_sel  = 1'b0;
        rd_sel     = 1'b0;
        stb_rd_en  = 1'b0;

        case (current_state)
            IDLE: begin
                if (!stb_empty || stb_full) begin
                    drain_req  = 1'b1;
                    drain_w_en = 1'b1;
                    drain_sel  = 1'b1;
                    rd_sel     = 1'b1;
                    next_state = SB_CACHE_WRITE;
                end
            end

            SB_CACHE_WRITE: begin
                if (dcache2stb_ack) begin
                    // Write accepted, drop request and retire the head
                    drain_sel = 1'b1;
                    rd_sel    = 1'b1;
                    stb_rd_en = 1'b1;
                    if (stb_empty)
                        next_state = IDLE;
                end else if (!stb_empty) begin
                    drain_req  = 1'b1;  // Hold until ack
                    drain_w_en = 1'b1;
                    drain_sel  = 1'b1;
                    rd_sel     = 1'b1;
                end else begin
                    next_state = IDLE;  // Queue drained
                end
            end

            default: next_state = IDLE;
        endcase
    end

    // Bypass hands the cache request lines to the LSU
    always_comb begin
        if (stb_bypass) begin
            stb2dcache_req  = lsummu2stb_req;
            stb2dcache_w_en = lsummu2stb_w_en;
            dmem_sel_o      = dmem_sel_i;
        end else begin
            stb2dcache_req  = drain_req;
            stb2dcache_w_en = drain_w_en;
            dmem_sel_o      = drain_sel;
        end
    end

endmodule

/* store_buffer_top.sv */
module store_buffer_top import mem_access_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // LSU side
    input  logic              lsu_req,
    input  logic              lsu_w_en,
    input  logic              lsu_dmem_sel,
    input  logic [ADDR_W-1:0] lsu_addr,
    input  logic [DATA_W-1:0] lsu_wdata,
    input  store_size_t       lsu_size,
    input  logic              stb_bypass,   // Only while stb_empty is high
    output logic              stb_full,
    output logic              stb_empty,

    // Data cache write port
    output logic              dcache_req,
    output logic              dcache_w_en,
    output logic              dcache_dmem_sel,
    output logic [ADDR_W-1:0] dcache_addr,
    output logic [DATA_W-1:0] dcache_wdata,
    output logic [MASK_W-1:0] dcache_mask,
    input  logic              dcache_ack
);

    logic [ADDR_W-1:0] al_addr;
    logic [DATA_W-1:0] al_data;
    logic [MASK_W-1:0] al_mask;
    logic              stb_wr_en;
    logic              stb_rd_en;
    logic              rd_sel;

    // Buffered store strobe
    assign stb_wr_en = lsu_req && lsu_w_en && !stb_bypass && !stb_full;

    lsu_store_align u_align (
        .addr      (lsu_addr),
        .wdata     (lsu_wdata),
        .size      (lsu_size),
        .word_addr (al_addr),
        .lane_data (al_data),
        .byte_mask (al_mask)
    );

    // Aligned store feeds both the queue and the bypass path
    stb_datapath u_dp (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (stb_wr_en),
        .in_addr   (al_addr),
        .in_data   (al_data),
        .in_mask   (al_mask),
        .rd_en     (stb_rd_en),
        .rd_sel    (rd_sel),
        .byp_addr  (al_addr),
        .byp_data  (al_data),
        .byp_mask  (al_mask),
        .stb_full  (stb_full),
        .stb_empty (stb_empty),
        .out_addr  (dcache_addr),
        .out_data  (dcache_wdata),
        .out_mask  (dcache_mask)
    );

    stb_cache_controller u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .stb_full        (stb_full),
        .stb_empty       (stb_empty),
        .stb_bypass      (stb_bypass),
        .dcache2stb_ack  (dcache_ack),
        .lsummu2stb_w_en (lsu_w_en),
        .lsummu2stb_req  (lsu_req),
        .dmem_sel_i      (lsu_dmem_sel),
        .stb_rd_en       (stb_rd_en),
        .rd_sel          (rd_sel),
        .stb2dcache_req  (dcache_req),
        .stb2dcache_w_en (dcache_w_en),
        .dmem_sel_o      (dcache_dmem_sel)
    );

endmodule

/* tb_dcache_model.sv */
module tb_dcache_model import mem_access_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // Cache write port as seen from the store buffer
    input  logic              req,
    input  logic              w_en,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [MASK_W-1:0] mask,
    input  logic              stall,      // Holds back every ack
    output logic              ack,

    // Write accepted in the previous cycle
    output logic              log_valid,
    output logic [ADDR_W-1:0] log_addr,
    output logic [DATA_W-1:0] log_data,
    output logic [MASK_W-1:0] log_mask
);

    timeunit 1ns;
    timeprecision 1ps;

    int wait_cnt;
    int delay;  // Cycles of request before ack

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            log_valid <= 1'b0;
            log_addr  <= '0;
            log_data  <= '0;
            log_mask  <= '0;
            wait_cnt  <= 0;
            delay     <= 1;
        end else begin
            ack       <= 1'b0;   // One-cycle pulse
            log_valid <= 1'b0;
            if (!ack && req && w_en && !stall) begin
                if (wait_cnt + 1 >= delay) begin
                    ack       <= 1'b1;
                    log_valid <= 1'b1;
                    log_addr  <= addr;
                    log_data  <= wdata;
                    log_mask  <= mask;
                    wait_cnt  <= 0;
                    delay     <= int'($urandom_range(4, 1));
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule

/* tb_store_buffer.sv */
module tb_store_buffer import stb_pkg::*, mem_access_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_ENTRIES = 18;
    localparam int          TIMEOUT_CYC = 64 * NUM_ENTRIES + 200;
    localparam logic [31:0] SEED        = 32'h08ad4b6f;

    typedef struct {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        store_size_t       size;
        logic              bypass;
        logic              stall;     // Cache stalled while this group fills
        logic [ADDR_W-1:0] exp_addr;
        logic [DATA_W-1:0] exp_data;
        logic [MASK_W-1:0] exp_mask;
    } stim_t;

    logic              clk;
    logic              rst_n;
    logic              lsu_req;
    logic              lsu_w_en;
    logic              lsu_dmem_sel;
    logic [ADDR_W-1:0] lsu_addr;
    logic [DATA_W-1:0] lsu_wdata;
    store_size_t       lsu_size;
    logic              stb_bypass;
    logic              stb_full;
    logic              stb_empty;
    logic              dcache_req;
    logic              dcache_w_en;
    logic              dcache_dmem_sel;
    logic [ADDR_W-1:0] dcache_addr;
    logic [DATA_W-1:0] dcache_wdata;
    logic [MASK_W-1:0] dcache_mask;
    logic              dcache_ack;
    logic              cache_stall;
    logic              log_valid;
    logic [ADDR_W-1:0] log_addr;
    logic [DATA_W-1:0] log_data;
    logic [MASK_W-1:0] log_mask;

    stim_t stim_tab [NUM_ENTRIES];
    bit    entry_err [NUM_ENTRIES];
    int    exp_q [$];       // Entry indices in expected cache order
    int    error_cnt;
    int    test_cnt;
    int    fail_cnt;
    int    cycle_cnt;
    int    sb_idx;
    int    group_cnt;       // Stores accepted in the stalled group
    bit    full_seen;

    store_buffer_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .lsu_req         (lsu_req),
        .lsu_w_en        (lsu_w_en),
        .lsu_dmem_sel    (lsu_dmem_sel),
        .lsu_addr        (lsu_addr),
        .lsu_wdata       (lsu_wdata),
        .lsu_size        (lsu_size),
        .stb_bypass      (stb_bypass),
        .stb_full        (stb_full),
        .stb_empty       (stb_empty),
        .dcache_req      (dcache_req),
        .dcache_w_en     (dcache_w_en),
        .dcache_dmem_sel (dcache_dmem_sel),
        .dcache_addr     (dcache_addr),
        .dcache_wdata    (dcache_wdata),
        .dcache_mask     (dcache_mask),
        .dcache_ack      (dcache_ack)
    );

    tb_dcache_model u_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (dcache_req),
        .w_en      (dcache_w_en),
        .addr      (dcache_addr),
        .wdata     (dcache_wdata),
        .mask      (dcache_mask),
        .stall     (cache_stall),
        .ack       (dcache_ack),
        .log_valid (log_valid),
        .log_addr  (log_addr),
        .log_data  (log_data),
        .log_mask  (log_mask)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic set_entry(input int i, input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                             input store_size_t s, input logic byp, input logic stl,
                             input logic [ADDR_W-1:0] ea, input logic [DATA_W-1:0] ed,
                             input logic [MASK_W-1:0] em);
        stim_tab[i] = '{a, d, s, byp, stl, ea, ed, em};
    endtask

    task automatic fill_table();
        // Mixed sizes, word address, replicated lanes, byte mask
        set_entry(0, 32'h1000_0000, 32'hdead_beef, SIZE_WORD, 0, 0, 32'h1000_0000, 32'hdead_beef, 4'hf);
        set_entry(1, 32'h1000_0006, 32'h0000_a5c3, SIZE_HALF, 0, 0, 32'h1000_0004, 32'ha5c3_a5c3, 4'hc);
        set_entry(2, 32'h1000_0004, 32'h0000_1234, SIZE_HALF, 0, 0, 32'h1000_0004, 32'h1234_1234, 4'h3);
        set_entry(3, 32'h2000_0001, 32'h0000_007e, SIZE_BYTE, 0, 0, 32'h2000_0000, 32'h7e7e_7e7e, 4'h2);
        set_entry(4, 32'h2000_0003, 32'hffff_ff81, SIZE_BYTE, 0, 0, 32'h2000_0000, 32'h8181_8181, 4'h8);
        set_entry(5, 32'h2000_0002, 32'h0000_0055, SIZE_BYTE, 0, 0, 32'h2000_0000, 32'h5555_5555, 4'h4);
        set_entry(6, 32'h3000_0008, 32'hcafe_f00d, SIZE_WORD, 1, 0, 32'h3000_0008, 32'hcafe_f00d, 4'hf);
        // Nine stores against a stalled cache
        for (int k = 0; k < 9; k++) begin
            set_entry(7 + k, 32'h4000_0000 + 4 * k, 32'h9000_0000 + k, SIZE_WORD, 0, 1,
                      32'h4000_0000 + 4 * k, 32'h9000_0000 + k, 4'hf);
        end
        set_entry(16, 32'h5000_0002, 32'h0000_003c, SIZE_BYTE, 1, 0, 32'h5000_0000, 32'h3c3c_3c3c, 4'h4);
        set_entry(17, 32'h6000_000c, 32'h0bad_cafe, SIZE_WORD, 0, 0, 32'h6000_000c, 32'h0bad_cafe, 4'hf);
    endtask

    task automatic fail_check(input int idx, input string msg);
        error_cnt++;
        if (idx >= 0)
            entry_err[idx] = 1'b1;
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic check_addr(input int idx, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp)
            fail_check(idx, $sformatf("entry %0d address %h, expected %h", idx, got, exp));
    endtask

    task automatic check_data(input int idx, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp)
            fail_check(idx, $sformatf("entry %0d data %h, expected %h", idx, got, exp));
    endtask

    task automatic check_mask(input int idx, input logic [MASK_W-1:0] got,
                              input logic [MASK_W-1:0] exp);
        if (got !== exp)
            fail_check(idx, $sformatf("entry %0d mask %b, expected %b", idx, got, exp));
    endtask

    // Live lane count must match the store size
    task automatic check_size(input int idx, input store_size_t size,
                              input logic [MASK_W-1:0] got_mask);
        int lanes;
        case (size)
            SIZE_BYTE: lanes = 1;
            SIZE_HALF: lanes = 2;
            default:   lanes = 4;
        endcase
        if ($countones(got_mask) != lanes)
            fail_check(idx, $sformatf("entry %0d size %s has mask %b", idx, size.name(),
                                      got_mask));
    endtask

    task automatic check_state(input string what, input stb_state_t got,
                               input stb_state_t exp);
        if (got !== exp)
            fail_check(-1, $sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
    endtask

    task automatic check_flag(input int idx, input string what, input logic got,
                              input logic exp);
        if (got !== exp)
            fail_check(idx, $sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic report_test(input string name, input bit failed);
        test_cnt++;
        if (failed)
            fail_cnt++;
        $display("Test %0d %s: %s", test_cnt, name, failed ? "fail" : "ok");
    endtask

    task automatic idle_lsu();
        lsu_req    <= 1'b0;
        lsu_w_en   <= 1'b0;
        stb_bypass <= 1'b0;
    endtask

    task automatic wait_until_empty();
        do @(posedge clk); while (!(stb_empty && exp_q.size() == 0));
    endtask

    // Holds the store until the buffer takes it and returns on the accepting edge
    task automatic run_store(input int i);
        bit accepted;
        int full_wait;
        accepted  = 0;
        full_wait = 0;
        lsu_req      <= 1'b1;
        lsu_w_en     <= 1'b1;
        lsu_dmem_sel <= 1'b1;
        stb_bypass   <= 1'b0;
        lsu_addr     <= stim_tab[i].addr;
        lsu_wdata    <= stim_tab[i].wdata;
        lsu_size     <= stim_tab[i].size;
        while (!accepted) begin
            @(posedge clk);
            if (!stb_full) begin
                accepted = 1;
            end else begin
                if (!full_seen) begin
                    full_seen = 1;
                    if (group_cnt != STB_DEPTH)
                        fail_check(i, $sformatf("stb_full rose after %0d stores", group_cnt));
                end
                full_wait++;
                if (full_wait == 6)
                    cache_stall <= 1'b0;  // Let the queue drain
            end
        end
        exp_q.push_back(i);
        if (stim_tab[i].stall)
            group_cnt++;
    endtask

    task automatic run_bypass(input int i);
        lsu_req      <= 1'b1;
        lsu_w_en     <= 1'b1;
        lsu_dmem_sel <= 1'b1;
        stb_bypass   <= 1'b1;
        lsu_addr     <= stim_tab[i].addr;
        lsu_wdata    <= stim_tab[i].wdata;
        lsu_size     <= stim_tab[i].size;
        @(posedge clk);
        // Same-cycle pass-through to the cache port
        check_flag(i, "bypass dcache_req", dcache_req, 1'b1);
        check_flag(i, "bypass dcache_w_en", dcache_w_en, 1'b1);
        check_flag(i, "bypass dcache_dmem_sel", dcache_dmem_sel, 1'b1);
        check_addr(i, dcache_addr, stim_tab[i].exp_addr);
        check_data(i, dcache_wdata, stim_tab[i].exp_data);
        check_mask(i, dcache_mask, stim_tab[i].exp_mask);
        exp_q.push_back(i);
        do @(posedge clk); while (!dcache_ack);
        idle_lsu();
        @(posedge clk);
        check_flag(i, "stb_empty after bypass", stb_empty, 1'b1);
    endtask

    // Scoreboard on the cache log
    always @(posedge clk) begin
        if (rst_n && log_valid) begin
            if (exp_q.size() == 0) begin
                error_cnt++;
                $display("Cache accepted a write at %0d ns with no store outstanding", $time);
            end else begin
                sb_idx = exp_q.pop_front();
                check_addr(sb_idx, log_addr, stim_tab[sb_idx].exp_addr);
                check_data(sb_idx, log_data, stim_tab[sb_idx].exp_data);
                check_mask(sb_idx, log_mask, stim_tab[sb_idx].exp_mask);
                check_size(sb_idx, stim_tab[sb_idx].size, log_mask);
                report_test($sformatf("entry %0d", sb_idx), entry_err[sb_idx]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int errs_before;
        void'($urandom(SEED));
        rst_n        = 1'b0;
        lsu_req      = 1'b0;
        lsu_w_en     = 1'b0;
        lsu_dmem_sel = 1'b0;
        lsu_addr     = '0;
        lsu_wdata    = '0;
        lsu_size     = SIZE_WORD;
        stb_bypass   = 1'b0;
        cache_stall  = 1'b0;
        error_cnt    = 0;
        test_cnt     = 0;
        fail_cnt     = 0;
        cycle_cnt    = 0;
        group_cnt    = 0;
        full_seen    = 0;
        fill_table();

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        errs_before = error_cnt;
        check_flag(-1, "dcache_req after reset", dcache_req, 1'b0);
        check_flag(-1, "dcache_w_en after reset", dcache_w_en, 1'b0);
        check_flag(-1, "dcache_dmem_sel after reset", dcache_dmem_sel, 1'b0);
        check_flag(-1, "stb_empty after reset", stb_empty, 1'b1);
        check_flag(-1, "stb_full after reset", stb_full, 1'b0);
        check_state("FSM state after reset", DUT.u_ctrl.current_state, IDLE);
        report_test("reset state", error_cnt != errs_before);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (stim_tab[i].bypass) begin
                idle_lsu();
                wait_until_empty();   // Bypass only on an empty buffer
                run_bypass(i);
            end else begin
                if (stim_tab[i].stall && group_cnt == 0) begin
                    idle_lsu();
                    wait_until_empty();
                    cache_stall <= 1'b1;
                end
                run_store(i);
            end
        end
        idle_lsu();
        if (!full_seen)
            fail_check(-1, "stb_full never rose in the stalled group");

        wait_until_empty();
        errs_before = error_cnt;
        repeat (4) begin
            @(posedge clk);
            check_flag(-1, "dcache_req when drained", dcache_req, 1'b0);
            check_flag(-1, "stb_empty when drained", stb_empty, 1'b1);
            check_state("FSM state when drained", DUT.u_ctrl.current_state, IDLE);
        end
        report_test("drained idle", error_cnt != errs_before);

        $display("Tests: %0d, failed tests: %0d, check errors: %0d",
                 test_cnt, fail_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
stb_pkg.sv
mem_access_pkg.sv
lsu_store_align.sv
stb_datapath.sv
stb_cache_controller.sv
store_buffer_top.sv
tb_dcache_model.sv
tb_store_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the store buffer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_store_buffer -o sim_store_buffer \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_store_buffer > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qxF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
